//--- Makefile
# Verilator build and run of the cartridge memory controller testbench

VERILATOR ?= verilator
TOP       ?= tb_cart
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/addr_map.sv
`timescale 1ns/1ps
`include "cart_consts.svh"
`default_nettype none

module addr_map (
   input  wire  [`CART_ADDR_W-1:0]  snes_addr,
   input  var   cart_pkg::mapper_e  mapper,
   input  wire  [19:0]              mgmt_addr,
   input  wire                      phase_mgmt,
   output logic [`CART_SRAM_AW-1:0] sram_addr,
   output logic                     lane_hi
);

   logic [19:0] snes_byte;
   logic [19:0] byte_addr;

   // Console byte address
   always_comb begin
      case (mapper)
         // A15 dropped, banks of 32K packed back to back
         cart_pkg::MAP_BANKED: snes_byte = {snes_addr[20:16], snes_addr[14:0]};
         default:              snes_byte = snes_addr[19:0];
      endcase
   end

   // Management half of the window owns the bus
   assign byte_addr = phase_mgmt ? mgmt_addr : snes_byte;

   // Word address plus lane select
   assign sram_addr = byte_addr[19:1];
   assign lane_hi   = byte_addr[0];

endmodule

`default_nettype wire

//--- source/cart_consts.svh
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH
`default_nettype none

// Console address bus, full 24 bits
`define CART_ADDR_W 24

// 512K x 16 SRAM word address
`define CART_SRAM_AW 19

// Twelve-slot access window
`define CART_SLOT_LAST 11
// Slots from here on belong to the management side
`define CART_MGMT_FIRST 6

// Flops per pin synchronizer
`define CART_SYNC_STAGES 2

`default_nettype wire
`endif

//--- source/cart_pkg.sv
`default_nettype none

package cart_pkg;

   // SPI opcodes, low nibble of the first byte after select
   typedef enum logic [3:0] {
      CMD_NOP        = 4'h0,
      CMD_SET_ADDR   = 4'h1,
      CMD_WRITE      = 4'h2,
      CMD_READ       = 4'h3,
      CMD_SET_MAPPER = 4'h4
   } cmd_op_e;

   // Console address translation
   typedef enum logic {
      MAP_LINEAR = 1'b0,
      MAP_BANKED = 1'b1
   } mapper_e;

   // Owner of the running window
   typedef enum logic [1:0] {
      SEQ_IDLE    = 2'd0,
      SEQ_CONSOLE = 2'd1,
      SEQ_MGMT    = 2'd2
   } slot_state_e;

endpackage

`default_nettype wire

//--- source/cart_top.sv
`timescale 1ns/1ps
`include "cart_consts.svh"
`default_nettype none

module cart_top (
   input  wire                      CLK2,
   input  wire                      arst_n,
   // Console bus
   input  wire  [`CART_ADDR_W-1:0]  snes_addr,
   input  wire                      snes_rd_n,
   input  wire                      snes_wr_n,
   input  wire                      snes_cs_n,
   input  wire  [7:0]               snes_data_in,
   output logic [7:0]               snes_data_out,
   output logic                     snes_data_oe,
   // SRAM
   output logic [`CART_SRAM_AW-1:0] sram_addr,
   output logic                     sram_oe_n,
   output logic                     sram_we_n,
   output logic                     sram_bhe_n,
   output logic                     sram_ble_n,
   input  wire  [15:0]              sram_dq_in,
   output logic [15:0]              sram_dq_out,
   output logic                     sram_dq_oe,
   // Management SPI
   input  wire                      sck,
   input  wire                      mosi,
   input  wire                      ss_n,
   output logic                     miso
);

   logic [7:0]        rx_byte;
   logic              rx_valid;
   logic              rx_first;
   logic [7:0]        tx_byte;
   cart_pkg::mapper_e mapper;
   logic              mgmt_valid;
   logic              mgmt_write;
   logic              mgmt_ready;
   logic [19:0]       mgmt_addr;
   logic [7:0]        mgmt_wdata;
   logic [7:0]        mgmt_rdata;
   logic              mgmt_rdata_valid;
   logic              phase_mgmt;
   logic              lane_hi;

   spi_byte_rx u_spi (
      .CLK2     (CLK2),
      .arst_n   (arst_n),
      .sck      (sck),
      .mosi     (mosi),
      .ss_n     (ss_n),
      .tx_byte  (tx_byte),
      .miso     (miso),
      .rx_byte  (rx_byte),
      .rx_valid (rx_valid),
      .rx_first (rx_first)
   );

   mgmt_cmd u_cmd (
      .CLK2             (CLK2),
      .arst_n           (arst_n),
      .rx_byte          (rx_byte),
      .rx_valid         (rx_valid),
      .rx_first         (rx_first),
      .mgmt_ready       (mgmt_ready),
      .mgmt_rdata       (mgmt_rdata),
      .mgmt_rdata_valid (mgmt_rdata_valid),
      .tx_byte          (tx_byte),
      .mapper           (mapper),
      .mgmt_valid       (mgmt_valid),
      .mgmt_write       (mgmt_write),
      .mgmt_addr        (mgmt_addr),
      .mgmt_wdata       (mgmt_wdata)
   );

   addr_map u_map (
      .snes_addr  (snes_addr),
      .mapper     (mapper),
      .mgmt_addr  (mgmt_addr),
      .phase_mgmt (phase_mgmt),
      .sram_addr  (sram_addr),
      .lane_hi    (lane_hi)
   );

   slot_sequencer u_seq (
      .CLK2             (CLK2),
      .arst_n           (arst_n),
      .snes_rd_n        (snes_rd_n),
      .snes_wr_n        (snes_wr_n),
      .snes_cs_n        (snes_cs_n),
      .snes_data_in     (snes_data_in),
      .lane_hi          (lane_hi),
      .sram_dq_in       (sram_dq_in),
      .mgmt_valid       (mgmt_valid),
      .mgmt_write       (mgmt_write),
      .mgmt_wdata       (mgmt_wdata),
      .phase_mgmt       (phase_mgmt),
      .sram_oe_n        (sram_oe_n),
      .sram_we_n        (sram_we_n),
      .sram_bhe_n       (sram_bhe_n),
      .sram_ble_n       (sram_ble_n),
      .sram_dq_out      (sram_dq_out),
      .sram_dq_oe       (sram_dq_oe),
      .snes_data_out    (snes_data_out),
      .snes_data_oe     (snes_data_oe),
      .mgmt_ready       (mgmt_ready),
      .mgmt_rdata       (mgmt_rdata),
      .mgmt_rdata_valid (mgmt_rdata_valid)
   );

endmodule

`default_nettype wire

//--- source/mgmt_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module mgmt_cmd (
   input  wire                      CLK2,
   input  wire                      arst_n,
   input  wire  [7:0]               rx_byte,
   input  wire                      rx_valid,
   input  wire                      rx_first,
   input  wire                      mgmt_ready,
   input  wire  [7:0]               mgmt_rdata,
   input  wire                      mgmt_rdata_valid,
   output logic [7:0]               tx_byte,
   output cart_pkg::mapper_e        mapper,
   output logic                     mgmt_valid,
   output logic                     mgmt_write,
   output logic [19:0]              mgmt_addr,
   output logic [7:0]               mgmt_wdata
);

   cart_pkg::cmd_op_e opcode;
   cart_pkg::cmd_op_e rx_op;
   logic [1:0]        param_cnt;
   logic [19:0]       addr_ptr;
   logic [19:0]       addr_next;

   assign rx_op = cart_pkg::cmd_op_e'(rx_byte[3:0]);

   // Pointer after a write taken this cycle
   assign addr_next = (mgmt_valid && mgmt_ready && mgmt_write) ? addr_ptr + 20'd1 : addr_ptr;

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         opcode     <= cart_pkg::CMD_NOP;
         param_cnt  <= 2'd0;
         addr_ptr   <= 20'd0;
         mapper     <= cart_pkg::MAP_LINEAR;
         mgmt_valid <= 1'b0;
         mgmt_write <= 1'b0;
         mgmt_addr  <= 20'd0;
         tx_byte    <= 8'd0;
      end else begin
         // Handshake done, autoincrement on writes
         if (mgmt_valid && mgmt_ready)
            mgmt_valid <= 1'b0;
         addr_ptr <= addr_next;
         if (mgmt_rdata_valid)
            tx_byte <= mgmt_rdata;

         if (rx_valid && rx_first) begin
            opcode    <= rx_op;
            param_cnt <= 2'd0;
            // Read goes out on the opcode itself
            if (rx_op == cart_pkg::CMD_READ) begin
               mgmt_valid <= 1'b1;
               mgmt_write <= 1'b0;
               mgmt_addr  <= addr_next;
            end
         end else if (rx_valid) begin
            case (opcode)
               cart_pkg::CMD_SET_ADDR: begin
                  // Three bytes, MSB first, top nibble dropped
                  case (param_cnt)
                     2'd0:    addr_ptr[19:16] <= rx_byte[3:0];
                     2'd1:    addr_ptr[15:8]  <= rx_byte;
                     default: addr_ptr[7:0]   <= rx_byte;
                  endcase
                  if (param_cnt != 2'd3)
                     param_cnt <= param_cnt + 2'd1;
               end
               cart_pkg::CMD_WRITE: begin
                  mgmt_valid <= 1'b1;
                  mgmt_write <= 1'b1;
                  mgmt_addr  <= addr_next;
               end
               cart_pkg::CMD_SET_MAPPER:
                  mapper <= cart_pkg::mapper_e'(rx_byte[0]);
               default: ;
            endcase
         end
      end
   end

   // Write payload
   always_ff @(posedge CLK2) begin
      if (rx_valid && !rx_first && opcode == cart_pkg::CMD_WRITE)
         mgmt_wdata <= rx_byte;
   end

   // Request held until the sequencer takes it
   a_req_stable: assert property (@(posedge CLK2) disable iff (!arst_n)
      mgmt_valid && !mgmt_ready |=> $stable(mgmt_addr) && $stable(mgmt_wdata));

endmodule

`default_nettype wire

//--- source/slot_sequencer.sv
`timescale 1ns/1ps
`include "cart_consts.svh"
`default_nettype none

module slot_sequencer (
   input  wire         CLK2,
   input  wire         arst_n,
   input  wire         snes_rd_n,
   input  wire         snes_wr_n,
   input  wire         snes_cs_n,
   input  wire  [7:0]  snes_data_in,
   input  wire         lane_hi,
   input  wire  [15:0] sram_dq_in,
   input  wire         mgmt_valid,
   input  wire         mgmt_write,
   input  wire  [7:0]  mgmt_wdata,
   output logic        phase_mgmt,
   output logic        sram_oe_n,
   output logic        sram_we_n,
   output logic        sram_bhe_n,
   output logic        sram_ble_n,
   output logic [15:0] sram_dq_out,
   output logic        sram_dq_oe,
   output logic [7:0]  snes_data_out,
   output logic        snes_data_oe,
   output logic        mgmt_ready,
   output logic [7:0]  mgmt_rdata,
   output logic        mgmt_rdata_valid
);

   localparam logic [3:0] SLOT_LAST  = 4'(`CART_SLOT_LAST);
   localparam logic [3:0] MGMT_FIRST = 4'(`CART_MGMT_FIRST);

   // {cs_n, rd_n, wr_n} per stage
   logic [`CART_SYNC_STAGES-1:0][2:0] pin_sync;
   logic                  cs_s;
   logic                  rd_s;
   logic                  wr_s;
   logic                  rw_d;
   logic                  cycle_start;
   logic                  start_pend;
   cart_pkg::slot_state_e state;
   logic [3:0]            slot;
   logic                  con_write;
   logic [7:0]            con_wdata;
   logic                  mgmt_act;
   logic                  mgmt_wr_lat;
   logic [7:0]            mgmt_wdata_lat;
   logic                  con_win;
   logic                  mgmt_rd;
   logic                  mgmt_wr;
   logic [7:0]            rd_byte;
   logic [7:0]            wr_byte;

   ////////////////////////////////////////////////////////////////////////////
   // Slot decode
   ////////////////////////////////////////////////////////////////////////////

   assign {cs_s, rd_s, wr_s} = pin_sync[`CART_SYNC_STAGES-1];
   assign con_win    = (state == cart_pkg::SEQ_CONSOLE) && (slot < MGMT_FIRST);
   assign phase_mgmt = (state != cart_pkg::SEQ_IDLE) && (slot >= MGMT_FIRST);
   assign mgmt_ready = phase_mgmt && (slot == MGMT_FIRST) && mgmt_valid;

   // Slot 6 sees the request itself, 7..11 the latched type
   assign mgmt_rd = (slot == MGMT_FIRST) ? (mgmt_ready && !mgmt_write)
                                         : (mgmt_act && !mgmt_wr_lat);
   assign mgmt_wr = mgmt_act && mgmt_wr_lat && (slot != SLOT_LAST);

   // Console read 0..5, console write 2..4
   assign sram_oe_n  = !((con_win && !con_write) || mgmt_rd);
   assign sram_we_n  = !((con_win && con_write && slot >= 4'd2 && slot <= 4'd4) || mgmt_wr);
   assign sram_bhe_n = !((!sram_oe_n || !sram_we_n) && lane_hi);
   assign sram_ble_n = !((!sram_oe_n || !sram_we_n) && !lane_hi);

   // Same byte on both halves, lane enables pick one
   assign wr_byte     = phase_mgmt ? mgmt_wdata_lat : con_wdata;
   assign sram_dq_out = {wr_byte, wr_byte};
   assign sram_dq_oe  = !sram_we_n;

   assign rd_byte          = lane_hi ? sram_dq_in[15:8] : sram_dq_in[7:0];
   assign mgmt_rdata       = rd_byte;
   assign mgmt_rdata_valid = mgmt_rd && (slot == SLOT_LAST);
   assign snes_data_oe     = !cs_s && !rd_s;

   ////////////////////////////////////////////////////////////////////////////
   // Cycle detection
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         pin_sync    <= '1;
         rw_d        <= 1'b1;
         cycle_start <= 1'b0;
      end else begin
         pin_sync    <= {pin_sync[`CART_SYNC_STAGES-2:0], {snes_cs_n, snes_rd_n, snes_wr_n}};
         rw_d        <= rd_s & wr_s;
         // Combined strobe falls with cart select low
         cycle_start <= rw_d && !(rd_s && wr_s) && !cs_s;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Window FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         state       <= cart_pkg::SEQ_IDLE;
         slot        <= 4'd0;
         start_pend  <= 1'b0;
         con_write   <= 1'b0;
         mgmt_act    <= 1'b0;
         mgmt_wr_lat <= 1'b0;
      end else begin
         if (cycle_start)
            con_write <= !wr_s;
         if (mgmt_ready) begin
            mgmt_act    <= 1'b1;
            mgmt_wr_lat <= mgmt_write;
         end
         case (state)
            cart_pkg::SEQ_IDLE: begin
               if (cycle_start) begin
                  state <= cart_pkg::SEQ_CONSOLE;
                  slot  <= 4'd0;
               end else if (mgmt_valid) begin
                  // Stand-alone window, console half skipped
                  state <= cart_pkg::SEQ_MGMT;
                  slot  <= MGMT_FIRST;
               end
            end
            default: begin
               if (slot == SLOT_LAST) begin
                  mgmt_act <= 1'b0;
                  if (cycle_start || start_pend) begin
                     state      <= cart_pkg::SEQ_CONSOLE;
                     slot       <= 4'd0;
                     start_pend <= 1'b0;
                  end else begin
                     state <= cart_pkg::SEQ_IDLE;
                     slot  <= 4'd0;
                  end
               end else begin
                  slot <= slot + 4'd1;
                  // Late console edge waits for slot 11
                  if (cycle_start)
                     start_pend <= 1'b1;
               end
            end
         endcase
      end
   end

   // Data latches
   always_ff @(posedge CLK2) begin
      if (cycle_start)
         con_wdata <= snes_data_in;
      if (mgmt_ready)
         mgmt_wdata_lat <= mgmt_wdata;
      // End of slot 4, held for the console until the next read
      if (con_win && !con_write && slot == 4'd4)
         snes_data_out <= rd_byte;
   end

   a_no_bus_fight: assert property (@(posedge CLK2) disable iff (!arst_n)
      !(!sram_oe_n && !sram_we_n));

   // A read taken in slot 6 answers in slot 11
   a_read_answer: assert property (@(posedge CLK2) disable iff (!arst_n)
      mgmt_ready && !mgmt_write |-> ##5 mgmt_rdata_valid);

endmodule

`default_nettype wire

//--- source/spi_byte_rx.sv
`timescale 1ns/1ps
`include "cart_consts.svh"
`default_nettype none

module spi_byte_rx (
   input  wire        CLK2,
   input  wire        arst_n,
   input  wire        sck,
   input  wire        mosi,
   input  wire        ss_n,
   input  wire  [7:0] tx_byte,
   output logic       miso,
   output logic [7:0] rx_byte,
   output logic       rx_valid,
   output logic       rx_first
);

   // {ss_n, sck, mosi} per stage
   logic [`CART_SYNC_STAGES-1:0][2:0] pin_sync;
   logic       ss_s;
   logic       sck_s;
   logic       mosi_s;
   logic       sck_d;
   logic       sck_rise;
   logic       sck_fall;
   logic [2:0] bit_cnt;
   logic [6:0] rx_shift;
   logic [7:0] tx_shift;
   logic       first_pend;

   assign {ss_s, sck_s, mosi_s} = pin_sync[`CART_SYNC_STAGES-1];
   assign sck_rise = sck_s & ~sck_d;
   assign sck_fall = ~sck_s & sck_d;
   assign miso     = tx_shift[7];

   // Pin synchronizers, idle as deselected with SCK low
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         pin_sync <= {`CART_SYNC_STAGES{3'b100}};
         sck_d    <= 1'b0;
      end else begin
         pin_sync <= {pin_sync[`CART_SYNC_STAGES-2:0], {ss_n, sck, mosi}};
         sck_d    <= sck_s;
      end
   end

   // Bit counter and byte strobe
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         bit_cnt    <= 3'd0;
         rx_valid   <= 1'b0;
         rx_first   <= 1'b0;
         first_pend <= 1'b1;
      end else begin
         rx_valid <= 1'b0;
         if (ss_s) begin
            bit_cnt    <= 3'd0;
            first_pend <= 1'b1;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               rx_valid   <= 1'b1;
               rx_first   <= first_pend;
               first_pend <= 1'b0;
            end
         end
      end
   end

   // MOSI sampled on rising SCK, MSB first
   always_ff @(posedge CLK2) begin
      if (!ss_s && sck_rise) begin
         rx_shift <= {rx_shift[5:0], mosi_s};
         if (bit_cnt == 3'd7)
            rx_byte <= {rx_shift, mosi_s};
      end
   end

   // Reply byte follows tx_byte between bytes
   // so a read result arriving late still goes out whole
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n)
         tx_shift <= 8'd0;
      else if (bit_cnt == 3'd0)
         tx_shift <= tx_byte;
      else if (sck_fall)
         tx_shift <= {tx_shift[6:0], 1'b0};
   end

   // Bytes complete only inside a select
   a_rx_in_select: assert property (@(posedge CLK2) disable iff (!arst_n)
      $rose(rx_valid) |-> !$past(ss_s));

endmodule

`default_nettype wire

//--- tb/cart_cases.txt
// Columns: action_address_data_expected in hex, one case per line
// 1 SPI write, 2 SPI burst, 3 console read, 4 console write, 5 write cs high,
// 6 SPI read, 7 mapper, 8 check burst, 9 burst during reads of the last burst
2_000100_06_00
8_000100_06_00
1_000200_11_00
1_000201_22_00
3_000200_00_11
3_000201_00_22
4_000300_3c_00
6_000300_00_3c
4_000310_a1_00
4_000311_b2_00
3_000310_00_a1
3_000311_00_b2
6_000311_00_b2
5_000310_99_00
3_000310_00_a1
1_008010_5a_00
7_000000_01_00
3_018010_00_5a
7_000000_00_00
9_000400_06_00
8_000400_06_00

//--- tb/tb_cart.sv
`timescale 1ns/1ps
`include "cart_consts.svh"
`default_nettype none

module tb_cart;

   localparam int SPI_HALF  = 8;
   localparam int MAX_CASES = 64;

   typedef logic [7:0] byte_q_t[$];

   logic                     CLK2;
   logic                     arst_n;
   logic [`CART_ADDR_W-1:0]  snes_addr;
   logic                     snes_rd_n;
   logic                     snes_wr_n;
   logic                     snes_cs_n;
   logic [7:0]               snes_data_in;
   logic [7:0]               snes_data_out;
   logic                     snes_data_oe;
   logic [`CART_SRAM_AW-1:0] sram_addr;
   logic                     sram_oe_n;
   logic                     sram_we_n;
   logic                     sram_bhe_n;
   logic                     sram_ble_n;
   logic [15:0]              sram_dq_in;
   logic [15:0]              sram_dq_out;
   logic                     sram_dq_oe;
   logic                     sck;
   logic                     mosi;
   logic                     ss_n;
   logic                     miso;

   // {action, address, data, expected}
   logic [43:0] cases [0:MAX_CASES-1];
   logic [15:0] sram [0:(1 << `CART_SRAM_AW)-1];
   // Last SPI burst, kept for later console reads
   byte_q_t     burst_q;
   logic [23:0] burst_base;
   logic [31:0] rng = 32'd17441;
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;
   int          limit = 0;

   cart_top dut (.*);

   ////////////////////////////////////////////////////////////////////////////
   // Clock, watchdog, SRAM model
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      CLK2 = 1'b0;
      forever #10 CLK2 = ~CLK2;
   end

   // Limit is zero until the cases are counted
   always @(posedge CLK2) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display("Simulation failed");
         $finish;
      end
   end

   // Fill from the whole word address
   initial begin
      for (int w = 0; w < (1 << `CART_SRAM_AW); w++)
         sram[w] <= 16'(w ^ (w >> 16));
   end

   // Async SRAM, only enabled lanes drive or store
   assign sram_dq_in = sram_oe_n ? 16'h0000 :
                       {sram_bhe_n ? 8'h00 : sram[sram_addr][15:8],
                        sram_ble_n ? 8'h00 : sram[sram_addr][7:0]};

   always @(posedge CLK2) begin
      if (!sram_we_n && sram_dq_oe) begin
         if (!sram_bhe_n)
            sram[sram_addr][15:8] <= sram_dq_out[15:8];
         if (!sram_ble_n)
            sram[sram_addr][7:0] <= sram_dq_out[7:0];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Rough cycle budget of one case
   function automatic int case_cycles(input logic [43:0] c);
      int spi_bytes;
      int reads;
      spi_bytes = 0;
      reads     = 0;
      case (c[43:40])
         4'h1, 4'h6: spi_bytes = 6;
         4'h2, 4'h9: spi_bytes = 5 + int'(c[15:8]);
         4'h7:       spi_bytes = 2;
         4'h8:       reads = int'(c[15:8]);
         default:    spi_bytes = 0;
      endcase
      return 400 + 160 * spi_bytes + 60 * reads;
   endfunction

   // Wait n edges, then the drive offset
   task automatic step(input int n);
      repeat (n) @(posedge CLK2);
      #2;
   endtask

   task automatic check_val(input string what, input logic [23:0] a,
                            input logic [7:0] got, input logic [7:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("mismatch at %0d ns: %s addr %06h got %02h expected %02h",
                  $time, what, a, got, exp);
      end
   endtask

   // One console strobe, 24 low then 20 high
   task automatic console_cycle(input logic [23:0] a, input logic wr, input logic sel,
                                input logic [7:0] d, output logic [7:0] q,
                                output logic oe);
      snes_addr    = a;
      snes_data_in = d;
      snes_cs_n    = !sel;
      snes_rd_n    = wr;
      snes_wr_n    = !wr;
      step(23);
      // Last cycle of the strobe
      q  = snes_data_out;
      oe = snes_data_oe;
      step(1);
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      snes_cs_n = 1'b1;
      step(20);
   endtask

   task automatic console_read(input logic [23:0] a, input logic [7:0] exp);
      logic [7:0] q;
      logic       oe;
      console_cycle(a, 1'b0, 1'b1, 8'h00, q, oe);
      check_val("console read", a, q, exp);
      check_val("snes_data_oe", a, {7'd0, oe}, 8'h01);
   endtask

   task automatic read_burst(input logic [23:0] a, input byte_q_t data, input int n);
      for (int i = 0; i < n; i++)
         console_read(a + 24'(i), data[i]);
   endtask

   // Mode 0, MSB first, MISO taken just before the rising SCK
   task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
      for (int i = 7; i >= 0; i--) begin
         mosi = tx[i];
         step(SPI_HALF);
         rx[i] = miso;
         sck   = 1'b1;
         step(SPI_HALF);
         sck = 1'b0;
      end
   endtask

   // One select frame, returns the last byte seen on MISO
   task automatic spi_frame(input byte_q_t tx, output logic [7:0] last_rx);
      ss_n = 1'b0;
      step(SPI_HALF);
      foreach (tx[i])
         spi_byte(tx[i], last_rx);
      step(SPI_HALF);
      ss_n = 1'b1;
      step(2 * SPI_HALF);
   endtask

   task automatic set_pointer(input logic [23:0] a);
      byte_q_t    q;
      logic [7:0] rx;
      q.push_back(8'h01);
      q.push_back(a[23:16]);
      q.push_back(a[15:8]);
      q.push_back(a[7:0]);
      spi_frame(q, rx);
   endtask

   task automatic spi_write(input logic [23:0] a, input byte_q_t data);
      byte_q_t    q;
      logic [7:0] rx;
      set_pointer(a);
      q.push_back(8'h02);
      foreach (data[i])
         q.push_back(data[i]);
      spi_frame(q, rx);
   endtask

   // Reply shifts out during the byte after the opcode
   task automatic spi_read(input logic [23:0] a, input logic [7:0] exp);
      byte_q_t    q;
      logic [7:0] rx;
      set_pointer(a);
      q.push_back(8'h03);
      q.push_back(8'h00);
      spi_frame(q, rx);
      check_val("SPI read", a, rx, exp);
   endtask

   task automatic set_mapper(input logic banked);
      byte_q_t    q;
      logic [7:0] rx;
      q.push_back(8'h04);
      q.push_back({7'd0, banked});
      spi_frame(q, rx);
   endtask

   task automatic make_burst(input int n);
      burst_q.delete();
      repeat (n) begin
         rng = xorshift(rng);
         burst_q.push_back(rng[7:0]);
      end
   endtask

   task automatic run_case(input logic [43:0] c);
      logic [3:0]  act;
      logic [23:0] a;
      logic [7:0]  d;
      logic [7:0]  exp;
      logic [7:0]  q;
      logic        oe;
      byte_q_t     one;
      byte_q_t     old_q;
      logic [23:0] old_base;
      {act, a, d, exp} = c;
      case (act)
         4'h1: begin
            one.push_back(d);
            spi_write(a, one);
         end
         4'h2: begin
            burst_base = a;
            make_burst(int'(d));
            spi_write(a, burst_q);
         end
         4'h3: console_read(a, exp);
         4'h4: console_cycle(a, 1'b1, 1'b1, d, q, oe);
         // Cart not selected, memory must keep its byte
         4'h5: console_cycle(a, 1'b1, 1'b0, d, q, oe);
         4'h6: spi_read(a, exp);
         4'h7: set_mapper(d[0]);
         4'h8: read_burst(a, burst_q, int'(d));
         4'h9: begin
            old_q      = burst_q;
            old_base   = burst_base;
            burst_base = a;
            make_burst(int'(d));
            // New SPI stream against reads of the previous one
            fork
               spi_write(a, burst_q);
               read_burst(old_base, old_q, old_q.size());
            join
         end
         default: begin
            errors++;
            $display("Case file holds an unknown action %0h", act);
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin : main
      int n;
      arst_n       = 1'b0;
      snes_addr    = '0;
      snes_rd_n    = 1'b1;
      snes_wr_n    = 1'b1;
      snes_cs_n    = 1'b1;
      snes_data_in = 8'h00;
      sck          = 1'b0;
      mosi         = 1'b0;
      ss_n         = 1'b1;
      for (n = 0; n < MAX_CASES; n++)
         cases[n] = '0;
      $readmemh("tb/cart_cases.txt", cases);
      // Action 0 ends the list
      limit = 1000;
      for (n = 0; n < MAX_CASES && cases[n][43:40] != 4'h0; n++)
         limit += case_cycles(cases[n]);

      repeat (8) @(posedge CLK2);
      #2;
      arst_n = 1'b1;
      step(4);
      check_val("idle strobes", 24'h0,
                {4'h0, sram_oe_n, sram_we_n, sram_bhe_n, sram_ble_n}, 8'h0f);
      check_val("idle snes_data_oe", 24'h0, {7'd0, snes_data_oe}, 8'h00);

      for (n = 0; n < MAX_CASES && cases[n][43:40] != 4'h0; n++)
         run_case(cases[n]);

      $display("Cases %0d, checks %0d, errors %0d", n, checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/cart_pkg.sv
source/spi_byte_rx.sv
source/mgmt_cmd.sv
source/addr_map.sv
source/slot_sequencer.sv
source/cart_top.sv
tb/tb_cart.sv
